// File: common/mul_pkg.sv
// multiplier package with op codes, widths, vector types, request structs and FSM states
`default_nettype none

package mul_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int xlen     = 64;   // operand and result width
  localparam int prod_w   = 130;  // widened multiplicand and accumulator
  localparam int mplier_w = 67;   // 65-bit multiplier plus sign bit and implicit zero

  typedef logic [xlen-1:0]     xlen_t;
  typedef logic [prod_w-1:0]   prod_t;
  typedef logic [mplier_w-1:0] mplier_t;
  typedef logic [4:0]          mul_op_t;  // one-hot op code

  // ==============================
  // operation codes
  // ==============================
  // mul     rd = (rs1 * rs2)[63:0]
  // mulh    rd = (rs1s * rs2s)[127:64]
  // mulhsu  rd = (rs1s * rs2u)[127:64]
  // mulhu   rd = (rs1u * rs2u)[127:64]
  // mulw    rd = sext((rs1 * rs2)[31:0])
  localparam mul_op_t op_mul    = 5'b00001;
  localparam mul_op_t op_mulh   = 5'b00010;
  localparam mul_op_t op_mulhsu = 5'b00100;
  localparam mul_op_t op_mulhu  = 5'b01000;
  localparam mul_op_t op_mulw   = 5'b10000;

  // ==============================
  // structs
  // ==============================
  typedef struct packed {
    mul_op_t op;            // which M-extension multiply
    xlen_t   multiplicand;  // rs1
    xlen_t   multiplier;    // rs2
  } mul_req_t;

  // operands after widening for the booth loop
  typedef struct packed {
    prod_t   mcand;   // sign or zero extended multiplicand
    mplier_t mplier;  // booth form, lsb is the implicit zero
  } mul_operands_t;

  // sequencer states
  typedef enum logic [1:0] {
    st_idle,
    st_multi,
    st_finish
  } mul_state_e;

endpackage

`default_nettype wire

// File: mul/mul_operand_ext.sv
// operand widening into booth multiplicand and multiplier by op signedness
`default_nettype none

module mul_operand_ext
  import mul_pkg::*;
(
  input  mul_req_t      req,
  output mul_operands_t operands
);

  logic is_mulw;
  logic mcand_unsigned;   // zero extend the multiplicand
  logic mplier_unsigned;  // zero extend the multiplier

  logic [xlen:0] mplier_65;  // 65-bit multiplier before booth padding

  // ==============================
  // op decode
  // ==============================
  // invalid codes fall through to signed widening like mul
  assign is_mulw         = (req.op == op_mulw);
  assign mcand_unsigned  = (req.op == op_mulhu) | is_mulw;
  assign mplier_unsigned = (req.op == op_mulhu) | (req.op == op_mulhsu) | is_mulw;

  // ==============================
  // multiplicand
  // ==============================
  always_comb begin
    operands.mcand[31:0] = req.multiplicand[31:0];
    if (is_mulw) begin
      operands.mcand[63:32] = '0;  // word op ignores upper half
    end else begin
      operands.mcand[63:32] = req.multiplicand[63:32];
    end
    if (mcand_unsigned) begin
      operands.mcand[prod_w-1:xlen] = '0;
    end else begin
      operands.mcand[prod_w-1:xlen] = {(prod_w-xlen){req.multiplicand[xlen-1]}};
    end
  end

  // ==============================
  // multiplier
  // ==============================
  always_comb begin
    mplier_65[31:0] = req.multiplier[31:0];
    if (is_mulw) begin
      mplier_65[63:32] = '0;
    end else begin
      mplier_65[63:32] = req.multiplier[63:32];
    end
    mplier_65[xlen] = mplier_unsigned ? 1'b0 : req.multiplier[xlen-1];
  end

  // booth needs an even width, so one more sign copy on top and a zero below
  assign operands.mplier = {mplier_65[xlen], mplier_65, 1'b0};

endmodule

`default_nettype wire

// File: mul/booth_pp_gen.sv
// radix-4 booth digit decode giving one partial product
`default_nettype none

module booth_pp_gen
  import mul_pkg::*;
(
  input  prod_t      mcand,
  input  logic [2:0] code,   // multiplier bits i+1, i, i-1
  output prod_t      pp
);

  // ==============================
  // digit decode
  // ==============================
  //  code      digit
  //  000 111    0
  //  001 010   +B
  //  011       +2B
  //  100       -2B
  //  101 110   -B
  prod_t mag;   // B or 2B before the sign is applied
  logic  neg;   // negative digit, invert and add one
  logic  zero;  // digit is zero

  always_comb begin
    mag  = mcand;
    neg  = 1'b0;
    zero = 1'b0;
    case (code)
      3'b001, 3'b010: begin
        mag = mcand;
      end
      3'b011: begin
        mag = {mcand[prod_w-2:0], 1'b0};  // 2B
      end
      3'b100: begin
        mag = {mcand[prod_w-2:0], 1'b0};
        neg = 1'b1;
      end
      3'b101, 3'b110: begin
        mag = mcand;
        neg = 1'b1;
      end
      default: begin
        zero = 1'b1;  // 000 and 111
      end
    endcase
  end

  // two's complement negate, wraps modulo 2^130
  always_comb begin
    if (zero) begin
      pp = '0;
    end else if (neg) begin
      pp = ~mag + prod_t'(1);
    end else begin
      pp = mag;
    end
  end

endmodule

`default_nettype wire

// File: mul/mul_seq.sv
// multiply FSM with shift registers, accumulator and op based result select
`default_nettype none

module mul_seq
  import mul_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  logic          mult_valid,   // start strobe, only looked at in idle
  input  mul_req_t      req,
  input  mul_operands_t operands,
  input  logic          result_ready,
  output prod_t         mcand_q,
  output logic [2:0]    code,
  input  prod_t         pp,
  output xlen_t         mult_out,
  output logic          mult_stall,
  output logic          result_ok
);

  mul_state_e state, next_state;

  mul_op_t op_q;       // latched op for result select
  mplier_t mplier_q;   // booth multiplier, shifts right
  prod_t   acc_q;      // running sum of partial products

  logic start;         // request taken this cycle
  logic mplier_done;   // no booth digits left
  logic accept;        // consumer takes the result

  assign start       = (state == st_idle) && mult_valid;
  assign mplier_done = ~|mplier_q;
  assign accept      = (state == st_finish) && result_ready;

  // ==============================
  // state register
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // ==============================
  // next state
  // ==============================
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (mult_valid) next_state = st_multi;
      end
      st_multi: begin
        if (mplier_done) next_state = st_finish;  // early stop
      end
      st_finish: begin
        if (result_ready) next_state = st_idle;
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  // ==============================
  // datapath registers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      op_q     <= '0;
      mcand_q  <= '0;
      mplier_q <= '0;
      acc_q    <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            op_q     <= req.op;
            mcand_q  <= operands.mcand;
            mplier_q <= operands.mplier;
            // a negative multiplier's top sign bit shifts down into one more +B digit
            acc_q    <= operands.mplier[mplier_w-1] ?
                        -(operands.mcand << (mplier_w-1)) : '0;
          end else begin
            op_q     <= '0;
            mcand_q  <= '0;
            mplier_q <= '0;
            acc_q    <= '0;
          end
        end
        st_multi: begin
          // nothing is added on the last pass
          if (!mplier_done) begin
            acc_q    <= acc_q + pp;
            mcand_q  <= mcand_q << 2;
            mplier_q <= mplier_q >> 2;
          end
        end
        st_finish: begin
          if (accept) begin
            op_q     <= '0;
            mcand_q  <= '0;
            mplier_q <= '0;
            acc_q    <= '0;
          end
        end
        default: begin
          op_q <= '0;
        end
      endcase
    end
  end

  assign code = mplier_q[2:0];  // current booth window

  // ==============================
  // result select
  // ==============================
  always_comb begin
    case (op_q)
      op_mul:                       mult_out = acc_q[xlen-1:0];
      op_mulh, op_mulhsu, op_mulhu: mult_out = acc_q[2*xlen-1:xlen];
      op_mulw:                      mult_out = {{32{acc_q[31]}}, acc_q[31:0]};
      default:                      mult_out = '0;  // invalid or cleared op
    endcase
  end

  // handshake levels
  assign mult_stall = start || (state == st_multi);
  assign result_ok  = (state == st_finish);

endmodule

`default_nettype wire

// File: src/mul_unit.sv
// multiply unit top joining request, operand widening, booth generator and sequencer
`default_nettype none

module mul_unit
  import mul_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    mult_valid,
  input  mul_op_t mult_type,
  input  xlen_t   multiplicand,
  input  xlen_t   multiplier,
  input  logic    result_ready,
  output xlen_t   mult_out,
  output logic    mult_stall,
  output logic    result_ok
);

  mul_req_t      req;
  mul_operands_t operands;   // widened, valid only in the start cycle
  prod_t         mcand_q;
  logic [2:0]    code;
  prod_t         pp;

  // request bundle
  assign req = '{op: mult_type, multiplicand: multiplicand, multiplier: multiplier};

  // ==============================
  // instances
  // ==============================
  mul_operand_ext mul_operand_ext_inst (
    .req      (req),
    .operands (operands)
  );

  booth_pp_gen booth_pp_gen_inst (
    .mcand (mcand_q),
    .code  (code),
    .pp    (pp)
  );

  mul_seq mul_seq_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_valid   (mult_valid),
    .req          (req),
    .operands     (operands),
    .result_ready (result_ready),
    .mcand_q      (mcand_q),
    .code         (code),
    .pp           (pp),
    .mult_out     (mult_out),
    .mult_stall   (mult_stall),
    .result_ok    (result_ok)
  );

endmodule

`default_nettype wire

// File: dv/mul_unit_assert.sv
// concurrent assertions on the multiply unit stall and result levels, bound to the top
`default_nettype none

module mul_unit_assert
  import mul_pkg::*;
(
  input logic  clk,
  input logic  rst_n,
  input logic  mult_stall,
  input logic  result_ok,
  input logic  result_ready,
  input xlen_t mult_out
);

  localparam int max_stall = 36;

  int stall_run;  // stall cycles before this one

  always_ff @(posedge clk) begin
    if (rst_n) begin
      stall_run <= 0;
    end else if (mult_stall) begin
      stall_run <= stall_run + 1;
    end else begin
      stall_run <= 0;
    end
  end

  // ==============================
  // handshake
  // ==============================
  stall_result_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(mult_stall && result_ok))
    else $error("mult_stall and result_ok high in the same cycle");

  result_hold: assert property (@(posedge clk) disable iff (rst_n)
    result_ok && !result_ready |=> result_ok && $stable(mult_out))
    else $error("result dropped or changed under back-pressure");

  stall_bound: assert property (@(posedge clk) disable iff (rst_n)
    mult_stall |-> stall_run < max_stall)
    else $error("mult_stall run longer than 36 cycles");

  result_taken: assert property (@(posedge clk) disable iff (rst_n)
    result_ok && result_ready |=> !result_ok)
    else $error("result_ok still high after acceptance");

endmodule

bind mul_unit mul_unit_assert mul_unit_assert_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .mult_stall   (mult_stall),
  .result_ok    (result_ok),
  .result_ready (result_ready),
  .mult_out     (mult_out)
);

`default_nettype wire

// File: dv/tb_mul_unit.sv
// testbench for the multiply unit with stimulus table, random cases, reference model and timeout
`default_nettype none

module tb_mul_unit
  import mul_pkg::*;
();

  // ==============================
  // stimulus table
  // ==============================
  typedef struct packed {
    mul_op_t    op;
    xlen_t      a;         // multiplicand
    xlen_t      b;         // multiplier
    logic [7:0] wait_cnt;  // cycles with result_ready low
  } case_t;

  localparam int n_table    = 21;
  localparam int n_random   = 40;
  localparam int rst_cycles = 16;
  localparam int max_stall  = 36;  // idle start cycle plus up to 35 loop cycles
  localparam int rand_wait  = 3;   // largest wait from two random bits

  logic    clk;
  logic    rst_n;
  logic    mult_valid;
  mul_op_t mult_type;
  xlen_t   multiplicand;
  xlen_t   multiplier;
  logic    result_ready;
  xlen_t   mult_out;
  logic    mult_stall;
  logic    result_ok;

  case_t       cases [n_table];
  int          n_loaded;
  logic [31:0] lfsr_state;
  int          cycle_cnt;
  int          cycle_limit;

  mul_unit mul_unit_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_valid   (mult_valid),
    .mult_type    (mult_type),
    .multiplicand (multiplicand),
    .multiplier   (multiplier),
    .result_ready (result_ready),
    .mult_out     (mult_out),
    .mult_stall   (mult_stall),
    .result_ok    (result_ok)
  );

  always #2 clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  // ==============================
  // helpers
  // ==============================
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic check_val(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // galois lfsr, shifts right
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd000_0001;
    end
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output xlen_t val);
    val = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val = {val[62:0], lfsr_state[0]};
    end
  endtask

  // product rules of the M extension on 128-bit values
  function automatic xlen_t ref_product(input mul_op_t op, input xlen_t a, input xlen_t b);
    logic [127:0] sa;
    logic [127:0] sb;
    logic [127:0] ua;
    logic [127:0] ub;
    logic [127:0] p;
    logic [63:0]  pw;
    sa = {{64{a[63]}}, a};
    sb = {{64{b[63]}}, b};
    ua = {64'b0, a};
    ub = {64'b0, b};
    pw = {32'b0, a[31:0]} * {32'b0, b[31:0]};
    case (op)
      op_mul: begin
        p = ua * ub;
        return p[63:0];
      end
      op_mulh: begin
        p = sa * sb;
        return p[127:64];
      end
      op_mulhsu: begin
        p = sa * ub;
        return p[127:64];
      end
      op_mulhu: begin
        p = ua * ub;
        return p[127:64];
      end
      op_mulw: return {{32{pw[31]}}, pw[31:0]};
      default: return '0;
    endcase
  endfunction

  task automatic add_case(input mul_op_t op, input xlen_t a, input xlen_t b, input int w);
    cases[n_loaded] = '{op: op, a: a, b: b, wait_cnt: 8'(w)};
    n_loaded++;
  endtask

  task automatic load_table();
    n_loaded = 0;
    add_case(op_mul,    64'd3,                  64'd5,                  0);
    add_case(op_mul,    '1,                     '1,                     1);
    add_case(op_mul,    64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 2);
    add_case(op_mulh,   '1,                     '1,                     0);
    add_case(op_mulh,   64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 3);
    add_case(op_mulh,   64'h7fff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 0);
    add_case(op_mulh,   64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff, 1);
    add_case(op_mulhsu, '1,                     '1,                     2);
    add_case(op_mulhsu, 64'h7fff_ffff_ffff_ffff, '1,                     0);
    add_case(op_mulhsu, 64'h8000_0000_0000_0000, 64'd1,                  0);
    add_case(op_mulhu,  '1,                     '1,                     5);
    add_case(op_mulhu,  64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
    add_case(op_mulhu,  64'd1,                  '1,                     0);
    // word ops, upper halves must not matter
    add_case(op_mulw,   64'hdead_beef_0001_0000, 64'h1234_5678_0000_8000, 0);
    add_case(op_mulw,   64'hffff_ffff_0000_0003, 64'h0000_0001_0000_0007, 2);
    add_case(op_mulw,   64'h0123_4567_ffff_ffff, 64'h89ab_cdef_ffff_ffff, 0);
    add_case(op_mulw,   64'h0000_0042_1234_5678, 64'hffff_ffff_0000_0000, 1);
    // zero multiplier, shortest loop
    add_case(op_mul,    64'h1234_5678_9abc_def0, 64'd0,                  0);
    add_case(op_mulhu,  '1,                     64'd0,                  3);
    // not one-hot
    add_case(5'b00011,  64'h0fed_cba9_8765_4321, 64'h0000_0000_0000_1111, 1);
    add_case(5'b00000,  64'd7,                  64'd9,                  0);
  endtask

  // ==============================
  // one multiply through the ports
  // ==============================
  task automatic run_case(input mul_op_t op, input xlen_t a, input xlen_t b, input int wait_cnt);
    xlen_t expected;
    xlen_t held;
    int    stall_cnt;
    expected = ref_product(op, a, b);
    @(negedge clk);
    mult_valid   = 1'b1;
    mult_type    = op;
    multiplicand = a;
    multiplier   = b;
    result_ready = (wait_cnt == 0);  // ready early means taken in the first finish cycle
    #1;
    check_val("mult_stall", 64'(mult_stall), 64'd1);
    check_val("result_ok", 64'(result_ok), 64'd0);
    stall_cnt = 1;
    @(negedge clk);
    mult_valid   = 1'b1;            // stray request while busy
    mult_type    = op_mul;
    multiplicand = ~a;
    multiplier   = ~b;
    #1;
    while (!result_ok) begin
      check_val("mult_stall", 64'(mult_stall), 64'd1);
      stall_cnt++;
      if (stall_cnt > max_stall) begin
        fail_now("mult_stall stayed high for more than 36 cycles");
      end
      @(negedge clk);
      mult_valid = 1'b0;
      #1;
    end
    check_val("mult_stall", 64'(mult_stall), 64'd0);
    check_val("mult_out", mult_out, expected);
    if (b == '0) begin
      check_val("mult_stall cycles", 64'(stall_cnt), 64'd2);
    end
    held = mult_out;
    for (int i = 1; i < wait_cnt; i++) begin
      @(negedge clk);
      mult_valid   = (i == 1);      // ignored in finish
      result_ready = 1'b0;
      #1;
      check_val("result_ok", 64'(result_ok), 64'd1);
      check_val("mult_out", mult_out, held);
    end
    if (wait_cnt > 0) begin
      @(negedge clk);
      mult_valid   = 1'b0;
      result_ready = 1'b1;
      #1;
      check_val("result_ok", 64'(result_ok), 64'd1);
      check_val("mult_out", mult_out, held);
    end
    @(negedge clk);
    mult_valid   = 1'b0;
    result_ready = 1'b0;
    #1;
    check_val("result_ok", 64'(result_ok), 64'd0);
    check_val("mult_stall", 64'(mult_stall), 64'd0);
    check_val("mult_out", mult_out, '0);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    int      max_wait;
    xlen_t   rnd;
    xlen_t   a;
    xlen_t   b;
    mul_op_t op;
    clk          = 1'b0;
    rst_n        = 1'b1;
    mult_valid   = 1'b0;
    mult_type    = '0;
    multiplicand = '0;
    multiplier   = '0;
    result_ready = 1'b0;
    cycle_cnt    = 0;
    lfsr_state   = 32'hb07f;
    load_table();
    max_wait = rand_wait;
    for (int i = 0; i < n_table; i++) begin
      if (int'(cases[i].wait_cnt) > max_wait) max_wait = int'(cases[i].wait_cnt);
    end
    cycle_limit = (n_table + n_random) * (max_stall + max_wait + 4) + rst_cycles;

    repeat (rst_cycles) @(negedge clk);
    rst_n = 1'b0;
    repeat (2) begin
      @(negedge clk);
      #1;
      check_val("mult_stall", 64'(mult_stall), 64'd0);
      check_val("result_ok", 64'(result_ok), 64'd0);
      check_val("mult_out", mult_out, '0);
    end

    for (int i = 0; i < n_table; i++) begin
      run_case(cases[i].op, cases[i].a, cases[i].b, int'(cases[i].wait_cnt));
    end

    for (int i = 0; i < n_random; i++) begin
      draw_bits(3, rnd);
      case (int'(rnd[2:0]) % 5)
        0:       op = op_mul;
        1:       op = op_mulh;
        2:       op = op_mulhsu;
        3:       op = op_mulhu;
        default: op = op_mulw;
      endcase
      draw_bits(64, a);
      draw_bits(64, b);
      draw_bits(6, rnd);
      b = b >> rnd[5:0];  // vary the loop length
      draw_bits(2, rnd);
      run_case(op, a, b, int'(rnd[1:0]));
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
common/mul_pkg.sv
mul/mul_operand_ext.sv
mul/booth_pp_gen.sv
mul/mul_seq.sv
src/mul_unit.sv
dv/mul_unit_assert.sv
dv/tb_mul_unit.sv

// File: Makefile
# Verilator build and run of the multiply unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mul_unit
FILELIST  := sim.f
LOG       := sim.log

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
